//--- files.f
+incdir+verif
src/fpMulPkg.sv
src/mulFrontEnd.sv
src/sgfMultiplication.sv
src/normRound.sv
src/fpMulTop.sv
verif/fpMulTb.sv

//--- src/fpMulPkg.sv
`default_nettype none

package fpMulPkg;

    ////////////////////////////////////////////////////////////
    // Single-precision format
    ////////////////////////////////////////////////////////////

    // Exponent field width
    localparam int ExpW = 8;

    // Significand width with the hidden bit
    localparam int SigW = 24;

    // Stored exponent bias
    localparam logic [ExpW-1:0] ExpBias = 8'd127;

    // All-ones exponent
    // Marks infinity or NaN depending on the fraction
    localparam logic [ExpW-1:0] ExpMax = 8'd255;

    // One packed word
    // Sign on top, then exponent, then the 23 fraction bits
    typedef logic [ExpW+SigW-1:0] float32T;

    ////////////////////////////////////////////////////////////
    // Special encodings
    ////////////////////////////////////////////////////////////

    // Canonical quiet NaN
    // Every NaN result leaves with this pattern
    localparam float32T QuietNan = 32'h7FC0_0000;

endpackage

`default_nettype wire

//--- src/fpMulTop.sv
`timescale 1ns/1ps
`default_nettype none

module fpMulTop (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire                     start_i,
    input  wire fpMulPkg::float32T  opA_i,
    input  wire fpMulPkg::float32T  opB_i,
    output fpMulPkg::float32T       result_o,
    output logic                    done_o,
    output logic                    overflow_o,
    output logic                    underflow_o,
    output logic                    invalid_o
);

    // Stage 1 significands and valid
    wire [fpMulPkg::SigW-1:0]          sigA;
    wire [fpMulPkg::SigW-1:0]          sigB;
    wire                               valid1;

    // Stage 2 side band
    wire                               sign2;
    wire signed [fpMulPkg::ExpW+1:0]   expSum2;
    wire                               isNan2;
    wire                               isInf2;
    wire                               isZero2;
    wire                               valid2;

    // Registered significand product
    wire [2*fpMulPkg::SigW-1:0]        sgfResult;

    ////////////////////////////////////////////////////////////
    // Pipeline, three cycles start to done
    ////////////////////////////////////////////////////////////

    mulFrontEnd i_mulFrontEnd (
        .clk       (clk),
        .rst_i     (rst_i),
        .start_i   (start_i),
        .opA_i     (opA_i),
        .opB_i     (opB_i),
        .sigA_o    (sigA),
        .sigB_o    (sigB),
        .valid1_o  (valid1),
        .sign2_o   (sign2),
        .expSum2_o (expSum2),
        .isNan2_o  (isNan2),
        .isInf2_o  (isInf2),
        .isZero2_o (isZero2),
        .valid2_o  (valid2)
    );

    // Loads one cycle after operand capture
    sgfMultiplication #(
        .SW (fpMulPkg::SigW)
    ) i_sgfMultiplication (
        .clk         (clk),
        .rst_i       (rst_i),
        .load_b_i    (valid1),
        .dataA_i     (sigA),
        .dataB_i     (sigB),
        .sgfResult_o (sgfResult)
    );

    normRound i_normRound (
        .clk         (clk),
        .rst_i       (rst_i),
        .valid2_i    (valid2),
        .sign2_i     (sign2),
        .expSum2_i   (expSum2),
        .isNan2_i    (isNan2),
        .isInf2_i    (isInf2),
        .isZero2_i   (isZero2),
        .sgfResult_i (sgfResult),
        .result_o    (result_o),
        .done_o      (done_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o),
        .invalid_o   (invalid_o)
    );

endmodule

`default_nettype wire

//--- src/mulFrontEnd.sv
`timescale 1ns/1ps
`default_nettype none

module mulFrontEnd (
    input  wire                              clk,
    input  wire                              rst_i,
    input  wire                              start_i,
    input  wire fpMulPkg::float32T           opA_i,
    input  wire fpMulPkg::float32T           opB_i,
    output logic [fpMulPkg::SigW-1:0]        sigA_o,
    output logic [fpMulPkg::SigW-1:0]        sigB_o,
    output logic                             valid1_o,
    output logic                             sign2_o,
    output logic signed [fpMulPkg::ExpW+1:0] expSum2_o,
    output logic                             isNan2_o,
    output logic                             isInf2_o,
    output logic                             isZero2_o,
    output logic                             valid2_o
);

    // Stage 1 operand registers
    fpMulPkg::float32T opAReg;
    fpMulPkg::float32T opBReg;

    // Unpacked fields
    logic                        signA;
    logic                        signB;
    logic [fpMulPkg::ExpW-1:0]   expA;
    logic [fpMulPkg::ExpW-1:0]   expB;
    logic [fpMulPkg::SigW-2:0]   fracA;
    logic [fpMulPkg::SigW-2:0]   fracB;

    // Per-operand class
    logic aZero;
    logic aInf;
    logic aNan;
    logic bZero;
    logic bInf;
    logic bNan;

    // Stage 2 next values
    logic                              signNext;
    logic signed [fpMulPkg::ExpW+1:0]  expSumNext;
    logic                              nanNext;
    logic                              infNext;
    logic                              zeroNext;

    ////////////////////////////////////////////////////////////
    // Stage 1 capture
    ////////////////////////////////////////////////////////////

    // Operands only move on a start
    always_ff @(posedge clk) begin
        if (start_i) begin
            opAReg <= opA_i;
            opBReg <= opB_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid1_o <= 1'b0;
        end else begin
            valid1_o <= start_i;
        end
    end

    // Field split
    assign {signA, expA, fracA} = opAReg;
    assign {signB, expB, fracB} = opBReg;

    // Zero exponent covers denormals too
    assign aZero = (expA == '0);
    assign bZero = (expB == '0);
    assign aInf  = (expA == fpMulPkg::ExpMax) && (fracA == '0);
    assign bInf  = (expB == fpMulPkg::ExpMax) && (fracB == '0);
    assign aNan  = (expA == fpMulPkg::ExpMax) && (fracA != '0);
    assign bNan  = (expB == fpMulPkg::ExpMax) && (fracB != '0);

    // Significands with hidden bit
    // Whole significand zeroed so denormals flush cleanly
    assign sigA_o = aZero ? '0 : {1'b1, fracA};
    assign sigB_o = bZero ? '0 : {1'b1, fracB};

    // Result sign
    assign signNext = signA ^ signB;

    // Biased sum, two spare bits for carry and sign
    assign expSumNext = {2'b00, expA} + {2'b00, expB} - {2'b00, fpMulPkg::ExpBias};

    // Result class, NaN wins over infinity wins over zero
    assign nanNext  = aNan | bNan | (aInf & bZero) | (bInf & aZero);
    assign infNext  = !nanNext && (aInf || bInf);
    assign zeroNext = !nanNext && !infNext && (aZero || bZero);

    ////////////////////////////////////////////////////////////
    // Stage 2, aligned with the product register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (valid1_o) begin
            sign2_o   <= signNext;
            expSum2_o <= expSumNext;
            isNan2_o  <= nanNext;
            isInf2_o  <= infNext;
            isZero2_o <= zeroNext;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid2_o <= 1'b0;
        end else begin
            valid2_o <= valid1_o;
        end
    end

    // Side band must be fully known whenever stage 2 is valid
    validChain: assert property (@(posedge clk) disable iff (rst_i)
        valid2_o |-> !$isunknown({sign2_o, expSum2_o, isNan2_o, isInf2_o, isZero2_o}));

endmodule

`default_nettype wire

//--- src/normRound.sv
`timescale 1ns/1ps
`default_nettype none

module normRound (
    input  wire                               clk,
    input  wire                               rst_i,
    input  wire                               valid2_i,
    input  wire                               sign2_i,
    input  wire signed [fpMulPkg::ExpW+1:0]   expSum2_i,
    input  wire                               isNan2_i,
    input  wire                               isInf2_i,
    input  wire                               isZero2_i,
    input  wire [2*fpMulPkg::SigW-1:0]        sgfResult_i,
    output fpMulPkg::float32T                 result_o,
    output logic                              done_o,
    output logic                              overflow_o,
    output logic                              underflow_o,
    output logic                              invalid_o
);

    // Normalization
    logic                              productTop;
    logic [fpMulPkg::SigW-1:0]         mant;
    logic                              guardBit;
    logic                              stickyBit;
    logic signed [fpMulPkg::ExpW+1:0]  expNorm;

    // Rounding
    logic                              roundUp;
    logic [fpMulPkg::SigW:0]           mantRnd;
    logic                              roundCarry;
    logic [fpMulPkg::SigW-2:0]         fracRnd;
    logic signed [fpMulPkg::ExpW+1:0]  expFinal;

    // Next register values
    fpMulPkg::float32T resultNext;
    logic              overflowNext;
    logic              underflowNext;
    logic              invalidNext;

    ////////////////////////////////////////////////////////////
    // Normalize
    ////////////////////////////////////////////////////////////

    // Product of two [1,2) values lies in [1,4)
    assign productTop = sgfResult_i[2*fpMulPkg::SigW-1];

    always_comb begin
        if (productTop) begin
            // Already in [2,4), take the top bits
            mant      = sgfResult_i[2*fpMulPkg::SigW-1:fpMulPkg::SigW];
            guardBit  = sgfResult_i[fpMulPkg::SigW-1];
            stickyBit = |sgfResult_i[fpMulPkg::SigW-2:0];
            expNorm   = expSum2_i + 1;
        end else begin
            // One position lower
            mant      = sgfResult_i[2*fpMulPkg::SigW-2:fpMulPkg::SigW-1];
            guardBit  = sgfResult_i[fpMulPkg::SigW-2];
            stickyBit = |sgfResult_i[fpMulPkg::SigW-3:0];
            expNorm   = expSum2_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Round to nearest even
    ////////////////////////////////////////////////////////////

    // Ties go to the even mantissa
    assign roundUp = guardBit & (stickyBit | mant[0]);
    assign mantRnd = {1'b0, mant} + {{fpMulPkg::SigW{1'b0}}, roundUp};

    // Carry out means all ones rolled over to the next power of two
    assign roundCarry = mantRnd[fpMulPkg::SigW];
    assign fracRnd    = roundCarry ? mantRnd[fpMulPkg::SigW-1:1]
                                   : mantRnd[fpMulPkg::SigW-2:0];
    assign expFinal   = expNorm + {{(fpMulPkg::ExpW+1){1'b0}}, roundCarry};

    // Special classes first, then range, then the rounded value
    always_comb begin
        overflowNext  = 1'b0;
        underflowNext = 1'b0;
        invalidNext   = 1'b0;
        if (isNan2_i) begin
            resultNext  = fpMulPkg::QuietNan;
            invalidNext = 1'b1;
        end else if (isInf2_i) begin
            resultNext = {sign2_i, fpMulPkg::ExpMax, {(fpMulPkg::SigW-1){1'b0}}};
        end else if (isZero2_i) begin
            resultNext = {sign2_i, {(fpMulPkg::ExpW+fpMulPkg::SigW-1){1'b0}}};
        end else if (expFinal >= int'(fpMulPkg::ExpMax)) begin
            // Signed compare against the saturation limit
            resultNext   = {sign2_i, fpMulPkg::ExpMax, {(fpMulPkg::SigW-1){1'b0}}};
            overflowNext = 1'b1;
        end else if (expFinal <= 0) begin
            // No denormal results, flush to signed zero
            resultNext    = {sign2_i, {(fpMulPkg::ExpW+fpMulPkg::SigW-1){1'b0}}};
            underflowNext = 1'b1;
        end else begin
            resultNext = {sign2_i, expFinal[fpMulPkg::ExpW-1:0], fracRnd};
        end
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            result_o    <= '0;
            done_o      <= 1'b0;
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
            invalid_o   <= 1'b0;
        end else begin
            done_o <= valid2_i;
            // Outputs hold until the next valid result
            if (valid2_i) begin
                result_o    <= resultNext;
                overflow_o  <= overflowNext;
                underflow_o <= underflowNext;
                invalid_o   <= invalidNext;
            end
        end
    end

    // Front end hands over at most one special class
    classExclusive: assert property (@(posedge clk) disable iff (rst_i)
        valid2_i |-> $onehot0({isNan2_i, isInf2_i, isZero2_i}));

endmodule

`default_nettype wire

//--- src/sgfMultiplication.sv
`timescale 1ns/1ps
`default_nettype none

module sgfMultiplication #(
    parameter int SW = 24
) (
    input  wire              clk,
    input  wire              rst_i,
    input  wire              load_b_i,
    input  wire [SW-1:0]     dataA_i,
    input  wire [SW-1:0]     dataB_i,
    output logic [2*SW-1:0]  sgfResult_o
);

    // Full product before the final register
    logic [2*SW-1:0] productComb;

    ////////////////////////////////////////////////////////////
    // One level of Karatsuba
    ////////////////////////////////////////////////////////////

    // Product = left << 2L + (middle - left - right) << L + right
    // L is the low half width
    generate
        case (SW % 2)
            0: begin : genEven
                // Halves
                logic [SW/2-1:0]   aHi;
                logic [SW/2-1:0]   aLo;
                logic [SW/2-1:0]   bHi;
                logic [SW/2-1:0]   bLo;
                // Partial products
                logic [2*(SW/2)-1:0] qLeft;
                logic [2*(SW/2)-1:0] qRight;
                // Half sums, one carry bit
                logic [SW/2:0]       sumA;
                logic [SW/2:0]       sumB;
                logic [2*(SW/2)+1:0] qMiddle;
                logic [2*(SW/2)+1:0] crossTerm;

                assign aHi = dataA_i[SW-1:SW/2];
                assign aLo = dataA_i[SW/2-1:0];
                assign bHi = dataB_i[SW-1:SW/2];
                assign bLo = dataB_i[SW/2-1:0];

                assign qLeft  = aHi * bHi;
                assign qRight = aLo * bLo;

                assign sumA    = {1'b0, aHi} + {1'b0, aLo};
                assign sumB    = {1'b0, bHi} + {1'b0, bLo};
                assign qMiddle = sumA * sumB;

                // Cross term aHi*bLo + aLo*bHi
                assign crossTerm = qMiddle - {2'b00, qLeft} - {2'b00, qRight};

                // Left and right sit side by side, cross term shifted by L
                assign productComb = {qLeft, qRight}
                    + {{(2*SW-(SW+SW/2+2)){1'b0}}, crossTerm, {(SW/2){1'b0}}};
            end
            1: begin : genOdd
                // Low half one bit wider
                logic [SW/2-1:0]     aHi;
                logic [SW/2:0]       aLo;
                logic [SW/2-1:0]     bHi;
                logic [SW/2:0]       bLo;
                logic [2*(SW/2)-1:0] qLeft;
                logic [2*(SW/2)+1:0] qRight;
                // Two spare bits on the sums
                logic [SW/2+1:0]     sumA;
                logic [SW/2+1:0]     sumB;
                logic [2*(SW/2)+3:0] qMiddle;
                logic [2*(SW/2)+3:0] crossTerm;

                assign aHi = dataA_i[SW-1:SW/2+1];
                assign aLo = dataA_i[SW/2:0];
                assign bHi = dataB_i[SW-1:SW/2+1];
                assign bLo = dataB_i[SW/2:0];

                assign qLeft  = aHi * bHi;
                assign qRight = aLo * bLo;

                assign sumA    = {2'b00, aHi} + {1'b0, aLo};
                assign sumB    = {2'b00, bHi} + {1'b0, bLo};
                assign qMiddle = sumA * sumB;

                assign crossTerm = qMiddle - {4'b0000, qLeft} - {2'b00, qRight};

                // Shift by the wider low half
                assign productComb = {qLeft, qRight}
                    + {{(2*SW-(3*(SW/2)+5)){1'b0}}, crossTerm, {(SW/2+1){1'b0}}};
            end
        endcase
    endgenerate

    ////////////////////////////////////////////////////////////
    // Final register
    ////////////////////////////////////////////////////////////

    // Holds between loads
    always_ff @(posedge clk) begin
        if (rst_i) begin
            sgfResult_o <= '0;
        end else if (load_b_i) begin
            sgfResult_o <= productComb;
        end
    end

    // Front end must hand over fully known significands
    knownProduct: assert property (@(posedge clk) disable iff (rst_i)
        load_b_i |=> !$isunknown(sgfResult_o));

endmodule

`default_nettype wire

//--- verif/fpMulModel.svh
`ifndef FPMULMODEL_SVH
`define FPMULMODEL_SVH

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

// Expected word and flags for one multiply
// Denormals flushed, nearest-even, saturating range
function automatic void modelMul(
    input  fpMulPkg::float32T a,
    input  fpMulPkg::float32T b,
    output fpMulPkg::float32T res,
    output logic              ovf,
    output logic              unf,
    output logic              inv
);
    logic [7:0]  ea;
    logic [7:0]  eb;
    logic [22:0] fa;
    logic [22:0] fb;
    logic        sgn;
    logic        zeroA;
    logic        zeroB;
    logic        infA;
    logic        infB;
    logic        nanA;
    logic        nanB;
    logic [47:0] prod;
    logic [47:0] rem;
    logic [47:0] half;
    logic [24:0] mant;
    int          shift;
    int          e;

    ea  = a[30:23];
    eb  = b[30:23];
    fa  = a[22:0];
    fb  = b[22:0];
    sgn = a[31] ^ b[31];
    ovf = 1'b0;
    unf = 1'b0;
    inv = 1'b0;

    // Zero exponent means zero, fraction ignored
    zeroA = (ea == 8'h00);
    zeroB = (eb == 8'h00);
    infA  = (ea == 8'hFF) && (fa == 0);
    infB  = (eb == 8'hFF) && (fb == 0);
    nanA  = (ea == 8'hFF) && (fa != 0);
    nanB  = (eb == 8'hFF) && (fb != 0);

    if (nanA || nanB || (infA && zeroB) || (infB && zeroA)) begin
        res = fpMulPkg::QuietNan;
        inv = 1'b1;
    end else if (infA || infB) begin
        res = {sgn, 8'hFF, 23'd0};
    end else if (zeroA || zeroB) begin
        res = {sgn, 31'd0};
    end else begin
        // Full integer product of the two 24-bit significands
        prod = 48'({1'b1, fa}) * 48'({1'b1, fb});
        // Keep 24 bits starting at the leading one
        shift = prod[47] ? 24 : 23;
        e     = int'(ea) + int'(eb) - int'(fpMulPkg::ExpBias) + (prod[47] ? 1 : 0);
        mant  = 25'(prod >> shift);
        rem   = prod & ((48'd1 << shift) - 48'd1);
        half  = 48'd1 << (shift - 1);
        // Above half rounds up, exactly half goes to even
        if ((rem > half) || ((rem == half) && mant[0])) begin
            mant = mant + 25'd1;
        end
        // Rolled over to the next power of two
        if (mant[24]) begin
            mant = mant >> 1;
            e    = e + 1;
        end
        if (e >= 255) begin
            res = {sgn, 8'hFF, 23'd0};
            ovf = 1'b1;
        end else if (e <= 0) begin
            res = {sgn, 31'd0};
            unf = 1'b1;
        end else begin
            res = {sgn, 8'(e), mant[22:0]};
        end
    end
endfunction

////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////

task automatic checkResult(input string name, input fpMulPkg::float32T expVal,
                           input fpMulPkg::float32T actVal);
    checkCount++;
    if (actVal !== expVal) begin
        $display("ERR t=%0t %s expected %h actual %h", $time, name, expVal, actVal);
        errCount++;
    end
endtask

task automatic checkFlag(input string name, input logic expVal, input logic actVal);
    checkCount++;
    if (actVal !== expVal) begin
        $display("ERR t=%0t %s expected %b actual %b", $time, name, expVal, actVal);
        errCount++;
    end
endtask

`endif

//--- verif/fpMulTb.sv
`timescale 1ns/1ps
`default_nettype none

module fpMulTb;

    // Run length
    localparam int DirectedOps  = 22;
    localparam int RandomCount  = 200;
    localparam int TotalOps     = DirectedOps + RandomCount;
    localparam int TimeoutLimit = TotalOps * 4 + 200;

    // One pending operation
    typedef struct packed {
        fpMulPkg::float32T res;
        logic              ovf;
        logic              unf;
        logic              inv;
        int                startCycle;
    } expectT;

    logic              clk;
    logic              rst_i;
    logic              start_i;
    fpMulPkg::float32T opA_i;
    fpMulPkg::float32T opB_i;
    fpMulPkg::float32T result_o;
    logic              done_o;
    logic              overflow_o;
    logic              underflow_o;
    logic              invalid_o;

    int     errCount   = 0;
    int     checkCount = 0;
    int     opCount    = 0;
    int     cycleCount = 0;
    integer seed       = 97492;
    expectT expQ[$];

    `include "fpMulModel.svh"

    fpMulTop i_fpMulTop (
        .clk         (clk),
        .rst_i       (rst_i),
        .start_i     (start_i),
        .opA_i       (opA_i),
        .opB_i       (opB_i),
        .result_o    (result_o),
        .done_o      (done_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o),
        .invalid_o   (invalid_o)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // Run limit
    always @(posedge clk) begin
        if (cycleCount >= TimeoutLimit) begin
            $display("Timeout after %0d cycles with %0d results outstanding",
                     cycleCount, expQ.size());
            $display("TESTS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Done monitor
    ////////////////////////////////////////////////////////////

    // Outputs sampled on the falling edge, away from the register update
    always @(negedge clk) begin : doneMonitor
        expectT head;
        if (!rst_i) begin
            if (done_o) begin
                if (expQ.size() == 0) begin
                    $display("done_o pulsed at time %0t with no operation pending", $time);
                    errCount++;
                end else begin
                    head = expQ.pop_front();
                    // Three cycles after the cycle that drove start
                    if (cycleCount != head.startCycle + 3) begin
                        $display("done_o for the start at cycle %0d came at cycle %0d, not 3 later",
                                 head.startCycle, cycleCount);
                        errCount++;
                    end
                    checkResult("result_o", head.res, result_o);
                    checkFlag("overflow_o", head.ovf, overflow_o);
                    checkFlag("underflow_o", head.unf, underflow_o);
                    checkFlag("invalid_o", head.inv, invalid_o);
                end
            end else if ((expQ.size() != 0) && (cycleCount > expQ[0].startCycle + 3)) begin
                $display("No done_o for the operation started at cycle %0d",
                         expQ[0].startCycle);
                errCount++;
                head = expQ.pop_front();
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////////////////////////

    // Start held high across consecutive calls
    task automatic issueOp(input fpMulPkg::float32T a, input fpMulPkg::float32T b);
        expectT item;
        @(negedge clk);
        opA_i   = a;
        opB_i   = b;
        start_i = 1'b1;
        modelMul(a, b, item.res, item.ovf, item.unf, item.inv);
        item.startCycle = cycleCount;
        expQ.push_back(item);
        opCount++;
    endtask

    task automatic waitDrain();
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic endBurst();
        @(negedge clk);
        start_i = 1'b0;
        waitDrain();
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic resetState();
        checkFlag("done_o", 1'b0, done_o);
        checkFlag("overflow_o", 1'b0, overflow_o);
        checkFlag("underflow_o", 1'b0, underflow_o);
        checkFlag("invalid_o", 1'b0, invalid_o);
        checkResult("result_o", '0, result_o);
    endtask

    task automatic exactProducts();
        issueOp(32'h4000_0000, 32'h4040_0000);
        issueOp(32'hBFC0_0000, 32'h4000_0000);
        issueOp(32'hC080_0000, 32'hBF00_0000);
        issueOp(32'h3E80_0000, 32'h4100_0000);
        issueOp(32'h40E0_0000, 32'h4110_0000);
        endBurst();
    endtask

    task automatic roundingCases();
        // Tie on an odd mantissa goes up
        issueOp(32'h3F80_0001, 32'h3FC0_0000);
        // Tie on an even mantissa stays
        issueOp(32'h3F80_0003, 32'h3FC0_0000);
        issueOp(32'h3F80_0001, 32'h3FC0_0001);
        issueOp(32'h3F80_0001, 32'h3FA0_0000);
        // Product just under 2.0 carries over to 2.0
        issueOp(32'h3FA1_E58F, 32'h3FCA_6691);
        endBurst();
    endtask

    task automatic specialOperands();
        issueOp(32'h7FC0_0000, 32'h3F80_0000);
        issueOp(32'h3F80_0000, 32'h7F80_0001);
        issueOp(32'h7F80_0000, 32'h0000_0000);
        issueOp(32'h8000_0000, 32'hFF80_0000);
        issueOp(32'h7F80_0000, 32'hC000_0000);
        issueOp(32'h8000_0000, 32'h40A0_0000);
        // Denormals behave as zero
        issueOp(32'h0000_0001, 32'h4040_0000);
        issueOp(32'h807F_FFFF, 32'h7F80_0000);
        endBurst();
    endtask

    task automatic rangeLimits();
        issueOp(32'h7F00_0000, 32'h4000_0000);
        issueOp(32'hFE00_0000, 32'h7E00_0000);
        issueOp(32'h0080_0000, 32'h3F00_0000);
        issueOp(32'h8D00_0000, 32'h0D00_0000);
        endBurst();
    endtask

    task automatic randomStream();
        fpMulPkg::float32T a;
        fpMulPkg::float32T b;
        for (int i = 0; i < RandomCount; i++) begin
            a = $random(seed);
            b = $random(seed);
            // Three in four pairs pulled into the normal range
            if (a[1:0] != 2'b00) begin
                a[30:23] = 8'd96 + 8'(a[7:2]);
            end
            if (b[1:0] != 2'b00) begin
                b[30:23] = 8'd96 + 8'(b[7:2]);
            end
            issueOp(a, b);
        end
        endBurst();
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst_i   = 1'b1;
        start_i = 1'b0;
        opA_i   = '0;
        opB_i   = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        resetState();
        exactProducts();
        roundingCases();
        specialOperands();
        rangeLimits();
        randomStream();
        // Catch any stray done pulse
        repeat (4) @(negedge clk);
        if (expQ.size() != 0) begin
            $display("%0d operations never completed", expQ.size());
            errCount++;
        end
        $display("Summary: %0d errors in %0d checks over %0d operations",
                 errCount, checkCount, opCount);
        if (errCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
